// ==== src/mmu_pkg.sv ====
// Translation datapath types
package mmu_pkg;

  // ------------------------------------------------------------------
  // sv39 address geometry
  // ------------------------------------------------------------------
  localparam int unsigned VLEN        = 39;
  localparam int unsigned PLEN        = 56;
  localparam int unsigned PPNW        = 44;
  localparam int unsigned VPNW        = 27;
  localparam int unsigned PAGE_OFFS_W = 12;
  // one vpn level covers 9 bits, three levels in sv39
  localparam int unsigned VPN_LVL_W   = 9;
  localparam int unsigned FLAGS_W     = 8;

  // flag positions in pte order, V at bit 0 up to D at bit 7
  localparam int unsigned FLAG_R = 1;
  localparam int unsigned FLAG_W = 2;
  localparam int unsigned FLAG_X = 3;
  localparam int unsigned FLAG_U = 4;
  localparam int unsigned FLAG_A = 6;
  localparam int unsigned FLAG_D = 7;

  // ------------------------------------------------------------------
  // address and entry types
  // ------------------------------------------------------------------
  typedef logic [VLEN-1:0]    vaddr_t;
  typedef logic [PLEN-1:0]    paddr_t;
  typedef logic [PPNW-1:0]    ppn_t;
  typedef logic [VPNW-1:0]    vpn_t;
  typedef logic [FLAGS_W-1:0] pte_flags_t;

  // leaf level of a tlb entry
  typedef enum logic [1:0] {
    PAGE_4K = 2'd0,
    PAGE_2M = 2'd1,
    PAGE_1G = 2'd2
  } page_size_e;

endpackage

// ==== src/mmu_csr_pkg.sv ====
// MMU control register map
package mmu_csr_pkg;

  localparam int unsigned CSR_ADDR_W = 4;

  // ------------------------------------------------------------------
  // register offsets
  // ------------------------------------------------------------------
  localparam logic [CSR_ADDR_W-1:0] REG_CTRL      = 4'd0;
  localparam logic [CSR_ADDR_W-1:0] REG_ENTRY_VPN = 4'd1;
  // a write here commits the staged entry to the tlb
  localparam logic [CSR_ADDR_W-1:0] REG_ENTRY_PTE = 4'd2;
  localparam logic [CSR_ADDR_W-1:0] REG_FLUSH     = 4'd3;

  // field positions inside the registers
  localparam int unsigned CTRL_EN_BIT    = 0;
  localparam int unsigned CTRL_PRIV_LSB  = 1;
  localparam int unsigned CTRL_SUM_BIT   = 3;
  localparam int unsigned CTRL_MXR_BIT   = 4;
  // page size sits right above the 27 bit vpn
  localparam int unsigned ENTRY_SIZE_LSB = 27;
  // ppn placed as in a real sv39 pte, flags in 7:0
  localparam int unsigned PTE_PPN_LSB    = 10;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // mcause encodings for the data side
  typedef enum logic [5:0] {
    LD_MISALIGNED   = 6'd4,
    LD_ACCESS_FAULT = 6'd5,
    ST_MISALIGNED   = 6'd6,
    ST_ACCESS_FAULT = 6'd7,
    LD_PAGE_FAULT   = 6'd13,
    ST_PAGE_FAULT   = 6'd15
  } exc_cause_e;

endpackage

// ==== src/mmu_cfg_regs.sv ====
// MMU configuration registers
`timescale 1ns/1ns

module mmu_cfg_regs (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               cfg_we_i,
  input  logic [mmu_csr_pkg::CSR_ADDR_W-1:0] cfg_addr_i,
  input  logic [63:0]                        cfg_wdata_i,
  output logic [63:0]                        cfg_rdata_o,
  output logic                               xlat_en_o,
  output mmu_csr_pkg::priv_lvl_e             priv_lvl_o,
  output logic                               sum_o,
  output logic                               mxr_o,
  output logic                               tlb_update_o,
  output logic                               tlb_flush_o,
  output mmu_pkg::vpn_t                      upd_vpn_o,
  output mmu_pkg::page_size_e                upd_size_o,
  output mmu_pkg::ppn_t                      upd_ppn_o,
  output mmu_pkg::pte_flags_t                upd_flags_o
);
  import mmu_pkg::*;
  import mmu_csr_pkg::*;

  logic wr_ctrl;
  logic wr_vpn;
  logic wr_pte;
  logic wr_flush;

  // write decode
  assign wr_ctrl  = cfg_we_i && (cfg_addr_i == REG_CTRL);
  assign wr_vpn   = cfg_we_i && (cfg_addr_i == REG_ENTRY_VPN);
  assign wr_pte   = cfg_we_i && (cfg_addr_i == REG_ENTRY_PTE);
  assign wr_flush = cfg_we_i && (cfg_addr_i == REG_FLUSH);

  // ------------------------------------------------------------------
  // control register and strobes
  // ------------------------------------------------------------------
  // comes out of reset untranslated in machine mode
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xlat_en_o    <= 1'b0;
      priv_lvl_o   <= PRIV_M;
      sum_o        <= 1'b0;
      mxr_o        <= 1'b0;
      tlb_update_o <= 1'b0;
      tlb_flush_o  <= 1'b0;
    end else begin
      // one cycle pulses, entry staging lands on the same edge
      tlb_update_o <= wr_pte;
      tlb_flush_o  <= wr_flush;
      if (wr_ctrl) begin
        xlat_en_o  <= cfg_wdata_i[CTRL_EN_BIT];
        priv_lvl_o <= priv_lvl_e'(cfg_wdata_i[CTRL_PRIV_LSB +: 2]);
        sum_o      <= cfg_wdata_i[CTRL_SUM_BIT];
        mxr_o      <= cfg_wdata_i[CTRL_MXR_BIT];
      end
    end
  end

  // staged tlb entry
  always_ff @(posedge clk_i) begin
    if (wr_vpn) begin
      upd_vpn_o  <= cfg_wdata_i[VPNW-1:0];
      upd_size_o <= page_size_e'(cfg_wdata_i[ENTRY_SIZE_LSB +: 2]);
    end
    if (wr_pte) begin
      upd_ppn_o   <= cfg_wdata_i[PTE_PPN_LSB +: PPNW];
      upd_flags_o <= cfg_wdata_i[FLAGS_W-1:0];
    end
  end

  // ------------------------------------------------------------------
  // read back
  // ------------------------------------------------------------------
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      REG_CTRL: begin
        cfg_rdata_o[CTRL_EN_BIT]          = xlat_en_o;
        cfg_rdata_o[CTRL_PRIV_LSB +: 2]   = priv_lvl_o;
        cfg_rdata_o[CTRL_SUM_BIT]         = sum_o;
        cfg_rdata_o[CTRL_MXR_BIT]         = mxr_o;
      end
      REG_ENTRY_VPN: begin
        cfg_rdata_o[VPNW-1:0]             = upd_vpn_o;
        cfg_rdata_o[ENTRY_SIZE_LSB +: 2]  = upd_size_o;
      end
      REG_ENTRY_PTE: begin
        cfg_rdata_o[FLAGS_W-1:0]          = upd_flags_o;
        cfg_rdata_o[PTE_PPN_LSB +: PPNW]  = upd_ppn_o;
      end
      // flush and unmapped offsets read as zero
      default: cfg_rdata_o = '0;
    endcase
  end

  // a single write can only raise one of the two strobes
  a_upd_flush_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tlb_update_o && tlb_flush_o));

endmodule

// ==== src/dtlb.sv ====
// Data TLB
`timescale 1ns/1ns

module dtlb #(
  parameter int unsigned TLB_ENTRIES = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                update_i,
  input  mmu_pkg::vpn_t       upd_vpn_i,
  input  mmu_pkg::page_size_e upd_size_i,
  input  mmu_pkg::ppn_t       upd_ppn_i,
  input  mmu_pkg::pte_flags_t upd_flags_i,
  input  mmu_pkg::vaddr_t     lu_vaddr_i,
  output logic                lu_hit_o,
  output mmu_pkg::ppn_t       lu_ppn_o,
  output mmu_pkg::page_size_e lu_size_o,
  output mmu_pkg::pte_flags_t lu_flags_o
);
  import mmu_pkg::*;

  // a single entry still needs a one bit pointer
  localparam int unsigned PTR_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  logic [TLB_ENTRIES-1:0] valid_q;
  vpn_t                   vpn_q   [TLB_ENTRIES];
  page_size_e             size_q  [TLB_ENTRIES];
  ppn_t                   ppn_q   [TLB_ENTRIES];
  pte_flags_t             flags_q [TLB_ENTRIES];

  logic [PTR_W-1:0]       ptr_q;
  logic [PTR_W-1:0]       upd_idx;
  logic                   upd_hit;
  logic [TLB_ENTRIES-1:0] hit_vec;
  vpn_t                   lu_vpn;

  // larger pages ignore the low vpn levels
  function automatic logic vpn_match(vpn_t tag, page_size_e size, vpn_t vpn);
    case (size)
      PAGE_1G: return tag[VPNW-1:2*VPN_LVL_W] == vpn[VPNW-1:2*VPN_LVL_W];
      PAGE_2M: return tag[VPNW-1:VPN_LVL_W] == vpn[VPNW-1:VPN_LVL_W];
      default: return tag == vpn;
    endcase
  endfunction

  assign lu_vpn = lu_vaddr_i[VLEN-1:PAGE_OFFS_W];

  // ------------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------------
  always_comb begin
    hit_vec    = '0;
    lu_hit_o   = 1'b0;
    lu_ppn_o   = '0;
    lu_size_o  = PAGE_4K;
    lu_flags_o = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (valid_q[i] && vpn_match(vpn_q[i], size_q[i], lu_vpn)) begin
        hit_vec[i] = 1'b1;
        lu_hit_o   = 1'b1;
        lu_ppn_o   = ppn_q[i];
        lu_size_o  = size_q[i];
        lu_flags_o = flags_q[i];
      end
    end
  end

  // ------------------------------------------------------------------
  // refill
  // ------------------------------------------------------------------
  // reuse an entry with identical vpn and size, else take the rr slot
  always_comb begin
    upd_hit = 1'b0;
    upd_idx = ptr_q;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (valid_q[i] && (vpn_q[i] == upd_vpn_i) && (size_q[i] == upd_size_i)) begin
        upd_hit = 1'b1;
        upd_idx = PTR_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      ptr_q   <= '0;
    end else if (flush_i) begin
      // flush leaves the pointer where it is
      valid_q <= '0;
    end else if (update_i) begin
      valid_q[upd_idx] <= 1'b1;
      if (!upd_hit) begin
        ptr_q <= (ptr_q == PTR_W'(TLB_ENTRIES - 1)) ? '0 : ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i && !flush_i) begin
      vpn_q[upd_idx]   <= upd_vpn_i;
      size_q[upd_idx]  <= upd_size_i;
      ppn_q[upd_idx]   <= upd_ppn_i;
      flags_q[upd_idx] <= upd_flags_i;
    end
  end

  // overlapping entries would make the lookup result ambiguous
  a_single_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_vec));

endmodule

// ==== src/pte_perm_check.sv ====
// PTE permission check
`timescale 1ns/1ns

module pte_perm_check (
  input  mmu_csr_pkg::priv_lvl_e priv_lvl_i,
  input  logic                   sum_i,
  input  logic                   mxr_i,
  input  logic                   is_store_i,
  input  mmu_pkg::pte_flags_t    flags_i,
  output logic                   page_fault_o
);
  import mmu_pkg::*;
  import mmu_csr_pkg::*;

  logic readable;

  // mxr lets execute-only pages be read
  assign readable = flags_i[FLAG_R] || (mxr_i && flags_i[FLAG_X]);

  always_comb begin
    page_fault_o = 1'b0;
    // machine mode bypasses every page check
    if (priv_lvl_i != PRIV_M) begin
      // accessed bit is not updated in hardware
      if (!flags_i[FLAG_A]) begin
        page_fault_o = 1'b1;
      end
      // user mode needs a user page
      if ((priv_lvl_i == PRIV_U) && !flags_i[FLAG_U]) begin
        page_fault_o = 1'b1;
      end
      // supervisor touches user pages only with sum set
      if ((priv_lvl_i == PRIV_S) && flags_i[FLAG_U] && !sum_i) begin
        page_fault_o = 1'b1;
      end
      if (!is_store_i && !readable) begin
        page_fault_o = 1'b1;
      end
      // dirty bit is also left to software
      if (is_store_i && (!flags_i[FLAG_W] || !flags_i[FLAG_D])) begin
        page_fault_o = 1'b1;
      end
    end
  end

endmodule

// ==== src/lsu_xlat_stage.sv ====
// Load/store translation stage
`timescale 1ns/1ns

module lsu_xlat_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    is_store_i,
  input  logic                    misaligned_i,
  input  logic                    xlat_en_i,
  input  logic [63:0]             vaddr_i,
  input  logic                    hit_i,
  input  mmu_pkg::ppn_t           ppn_i,
  input  mmu_pkg::page_size_e     size_i,
  input  mmu_pkg::pte_flags_t     flags_i,
  output logic                    store_q_o,
  output mmu_pkg::pte_flags_t     flags_q_o,
  input  logic                    page_fault_i,
  output logic                    valid_o,
  output logic                    miss_o,
  output mmu_pkg::paddr_t         paddr_o,
  output logic                    exc_valid_o,
  output mmu_csr_pkg::exc_cause_e exc_cause_o,
  output logic [63:0]             exc_tval_o
);
  import mmu_pkg::*;
  import mmu_csr_pkg::*;

  logic        req_q;
  logic        mis_q;
  logic        hit_q;
  logic [63:0] vaddr_q;
  ppn_t        ppn_q;
  page_size_e  size_q;
  vaddr_t      va_low;
  logic        canon;

  // ------------------------------------------------------------------
  // cycle 0 capture
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req_i;
    end
  end

  // request payload and tlb answer
  always_ff @(posedge clk_i) begin
    store_q_o <= is_store_i;
    mis_q     <= misaligned_i;
    vaddr_q   <= vaddr_i;
    hit_q     <= hit_i;
    ppn_q     <= ppn_i;
    size_q    <= size_i;
    flags_q_o <= flags_i;
  end

  // ------------------------------------------------------------------
  // cycle 1 result
  // ------------------------------------------------------------------
  assign va_low = vaddr_q[VLEN-1:0];
  // upper bits must all copy bit 38
  assign canon  = (&vaddr_q[63:VLEN-1]) || !(|vaddr_q[63:VLEN-1]);

  // no walker, so a miss just ends the request
  assign miss_o  = req_q && xlat_en_i && !mis_q && canon && !hit_q;
  assign valid_o = req_q && !miss_o;

  always_comb begin
    if (xlat_en_i) begin
      paddr_o = {ppn_q, va_low[PAGE_OFFS_W-1:0]};
      // superpages pass the low vpn levels through
      if (size_q == PAGE_2M) begin
        paddr_o[PAGE_OFFS_W +: VPN_LVL_W] = va_low[PAGE_OFFS_W +: VPN_LVL_W];
      end
      if (size_q == PAGE_1G) begin
        paddr_o[PAGE_OFFS_W +: 2*VPN_LVL_W] = va_low[PAGE_OFFS_W +: 2*VPN_LVL_W];
      end
    end else begin
      paddr_o = paddr_t'(va_low);
    end
  end

  // misaligned beats non-canonical beats page fault
  always_comb begin
    exc_valid_o = 1'b0;
    exc_cause_o = store_q_o ? ST_MISALIGNED : LD_MISALIGNED;
    if (mis_q) begin
      exc_valid_o = valid_o;
    end else if (!canon) begin
      exc_valid_o = valid_o;
      exc_cause_o = store_q_o ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
    end else if (xlat_en_i && hit_q && page_fault_i) begin
      exc_valid_o = valid_o;
      exc_cause_o = store_q_o ? ST_PAGE_FAULT : LD_PAGE_FAULT;
    end
  end

  assign exc_tval_o = vaddr_q;

  a_valid_miss_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(valid_o && miss_o));

endmodule

// ==== src/mmu_top.sv ====
// Data-side MMU top level
`timescale 1ns/1ns

module mmu_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               cfg_we_i,
  input  logic [mmu_csr_pkg::CSR_ADDR_W-1:0] cfg_addr_i,
  input  logic [63:0]                        cfg_wdata_i,
  output logic [63:0]                        cfg_rdata_o,
  input  logic                               lsu_req_i,
  input  logic [63:0]                        lsu_vaddr_i,
  input  logic                               lsu_is_store_i,
  input  logic                               lsu_misaligned_i,
  output logic                               lsu_dtlb_hit_o,
  output logic                               lsu_valid_o,
  output logic                               lsu_miss_o,
  output mmu_pkg::paddr_t                    lsu_paddr_o,
  output logic                               lsu_exc_valid_o,
  output mmu_csr_pkg::exc_cause_e            lsu_exc_cause_o,
  output logic [63:0]                        lsu_exc_tval_o
);
  import mmu_pkg::*;
  import mmu_csr_pkg::*;

  // translation controls
  logic       xlat_en;
  priv_lvl_e  priv_lvl;
  logic       sum;
  logic       mxr;
  // tlb refill path
  logic       tlb_update;
  logic       tlb_flush;
  vpn_t       upd_vpn;
  page_size_e upd_size;
  ppn_t       upd_ppn;
  pte_flags_t upd_flags;
  // lookup result and registered copies
  logic       lu_hit;
  ppn_t       lu_ppn;
  page_size_e lu_size;
  pte_flags_t lu_flags;
  logic       store_q;
  pte_flags_t flags_q;
  logic       page_fault;

  mmu_cfg_regs u_cfg_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_rdata_o  (cfg_rdata_o),
    .xlat_en_o    (xlat_en),
    .priv_lvl_o   (priv_lvl),
    .sum_o        (sum),
    .mxr_o        (mxr),
    .tlb_update_o (tlb_update),
    .tlb_flush_o  (tlb_flush),
    .upd_vpn_o    (upd_vpn),
    .upd_size_o   (upd_size),
    .upd_ppn_o    (upd_ppn),
    .upd_flags_o  (upd_flags)
  );

  dtlb #(
    .TLB_ENTRIES (4)
  ) u_dtlb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (tlb_flush),
    .update_i    (tlb_update),
    .upd_vpn_i   (upd_vpn),
    .upd_size_i  (upd_size),
    .upd_ppn_i   (upd_ppn),
    .upd_flags_i (upd_flags),
    .lu_vaddr_i  (lsu_vaddr_i[VLEN-1:0]),
    .lu_hit_o    (lu_hit),
    .lu_ppn_o    (lu_ppn),
    .lu_size_o   (lu_size),
    .lu_flags_o  (lu_flags)
  );

  // untranslated accesses always hit
  assign lsu_dtlb_hit_o = xlat_en ? lu_hit : 1'b1;

  lsu_xlat_stage u_xlat (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (lsu_req_i),
    .is_store_i   (lsu_is_store_i),
    .misaligned_i (lsu_misaligned_i),
    .xlat_en_i    (xlat_en),
    .vaddr_i      (lsu_vaddr_i),
    .hit_i        (lu_hit),
    .ppn_i        (lu_ppn),
    .size_i       (lu_size),
    .flags_i      (lu_flags),
    .store_q_o    (store_q),
    .flags_q_o    (flags_q),
    .page_fault_i (page_fault),
    .valid_o      (lsu_valid_o),
    .miss_o       (lsu_miss_o),
    .paddr_o      (lsu_paddr_o),
    .exc_valid_o  (lsu_exc_valid_o),
    .exc_cause_o  (lsu_exc_cause_o),
    .exc_tval_o   (lsu_exc_tval_o)
  );

  // checker sees the flags captured with the request
  pte_perm_check u_perm (
    .priv_lvl_i   (priv_lvl),
    .sum_i        (sum),
    .mxr_i        (mxr),
    .is_store_i   (store_q),
    .flags_i      (flags_q),
    .page_fault_o (page_fault)
  );

endmodule

// ==== verif/mmu_model.svh ====
// Data MMU reference model
`ifndef MMU_MODEL_SVH
`define MMU_MODEL_SVH

  localparam int unsigned M_ENTRIES = 4;

  // expected response of one request, tag is the cycle it was issued in
  typedef struct packed {
    logic [31:0] tag;
    logic        dhit;
    logic        miss;
    logic        exc;
    logic [5:0]  cause;
    logic [55:0] paddr;
    logic [63:0] tval;
  } exp_t;

  // ------------------------------------------------------------------
  // model state
  // ------------------------------------------------------------------
  logic        m_valid [M_ENTRIES];
  logic [26:0] m_vpn   [M_ENTRIES];
  logic [1:0]  m_size  [M_ENTRIES];
  logic [43:0] m_ppn   [M_ENTRIES];
  logic [7:0]  m_flags [M_ENTRIES];
  int          m_ptr;
  logic        m_en;
  logic [1:0]  m_priv;
  logic        m_sum;
  logic        m_mxr;

  function automatic void model_reset();
    for (int i = 0; i < M_ENTRIES; i++) begin
      m_valid[i] = 1'b0;
    end
    m_ptr  = 0;
    m_en   = 1'b0;
    m_priv = PRIV_M;
    m_sum  = 1'b0;
    m_mxr  = 1'b0;
  endfunction

  // pointer stays put on a flush
  function automatic void model_flush();
    for (int i = 0; i < M_ENTRIES; i++) begin
      m_valid[i] = 1'b0;
    end
  endfunction

  // same vpn and size overwrites in place, otherwise the oldest slot goes
  function automatic void model_refill(input logic [26:0] vpn, input logic [1:0] size,
                                       input logic [43:0] ppn, input logic [7:0] flags);
    int idx;
    idx = -1;
    for (int i = 0; i < M_ENTRIES; i++) begin
      if (m_valid[i] && (m_vpn[i] == vpn) && (m_size[i] == size)) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      idx   = m_ptr;
      m_ptr = (m_ptr + 1) % M_ENTRIES;
    end
    m_valid[idx] = 1'b1;
    m_vpn[idx]   = vpn;
    m_size[idx]  = size;
    m_ppn[idx]   = ppn;
    m_flags[idx] = flags;
  endfunction

  // index of the matching entry, -1 on a miss
  function automatic int model_lookup(input logic [63:0] va);
    int idx;
    idx = -1;
    for (int i = 0; i < M_ENTRIES; i++) begin
      if (m_valid[i]) begin
        case (m_size[i])
          PAGE_1G: if (va[38:30] == m_vpn[i][26:18]) idx = i;
          PAGE_2M: if (va[38:21] == m_vpn[i][26:9]) idx = i;
          default: if (va[38:12] == m_vpn[i]) idx = i;
        endcase
      end
    end
    return idx;
  endfunction

  // flags are V R W X U G A D from bit 0 up
  function automatic logic model_fault(input logic [7:0] fl, input logic st);
    logic f;
    f = 1'b0;
    if (m_priv != PRIV_M) begin
      f = !fl[6];
      f = f | ((m_priv == PRIV_U) && !fl[4]);
      f = f | ((m_priv == PRIV_S) && fl[4] && !m_sum);
      f = f | (!st && !(fl[1] || (m_mxr && fl[3])));
      f = f | (st && !(fl[2] && fl[7]));
    end
    return f;
  endfunction

  function automatic exp_t model_expect(input logic [63:0] va, input logic st,
                                        input logic mis, input logic [31:0] tag);
    exp_t e;
    int   idx;
    logic canon;
    e      = '0;
    e.tag  = tag;
    e.tval = va;
    canon  = (va[63:38] == {26{va[38]}});
    idx    = model_lookup(va);
    e.dhit = !m_en || (idx >= 0);
    e.miss = m_en && !mis && canon && (idx < 0);
    if (!m_en) begin
      e.paddr = {17'd0, va[38:0]};
    end else if (idx >= 0) begin
      // superpages keep the low vpn levels of the request
      case (m_size[idx])
        PAGE_1G: e.paddr = {m_ppn[idx][43:18], va[29:0]};
        PAGE_2M: e.paddr = {m_ppn[idx][43:9], va[20:0]};
        default: e.paddr = {m_ppn[idx], va[11:0]};
      endcase
    end
    if (mis) begin
      e.exc   = 1'b1;
      e.cause = st ? ST_MISALIGNED : LD_MISALIGNED;
    end else if (!canon) begin
      e.exc   = 1'b1;
      e.cause = st ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
    end else if (m_en && (idx >= 0) && model_fault(m_flags[idx], st)) begin
      e.exc   = 1'b1;
      e.cause = st ? ST_PAGE_FAULT : LD_PAGE_FAULT;
    end
    return e;
  endfunction

`endif

// ==== verif/mmu_tb.sv ====
// Data MMU testbench
`timescale 1ns/1ns

module mmu_tb;
  import mmu_pkg::*;
  import mmu_csr_pkg::*;

  `include "mmu_model.svh"

  logic        clk_i;
  logic        rst_ni;
  logic        cfg_we_i;
  logic [3:0]  cfg_addr_i;
  logic [63:0] cfg_wdata_i;
  logic [63:0] cfg_rdata_o;
  logic        lsu_req_i;
  logic [63:0] lsu_vaddr_i;
  logic        lsu_is_store_i;
  logic        lsu_misaligned_i;
  logic        lsu_dtlb_hit_o;
  logic        lsu_valid_o;
  logic        lsu_miss_o;
  paddr_t      lsu_paddr_o;
  logic        lsu_exc_valid_o;
  exc_cause_e  lsu_exc_cause_o;
  logic [63:0] lsu_exc_tval_o;

  integer      seed;
  int          cyc = 0;
  int          wait_cnt;
  string       test_name;
  logic [8:0]  next_top;
  exp_t        exp_q   [$];
  string       name_q  [$];
  // one address inside every entry ever loaded
  logic [63:0] hist_va [$];

  mmu_top u_dut (
    .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
    .lsu_req_i, .lsu_vaddr_i, .lsu_is_store_i, .lsu_misaligned_i,
    .lsu_dtlb_hit_o, .lsu_valid_o, .lsu_miss_o, .lsu_paddr_o,
    .lsu_exc_valid_o, .lsu_exc_cause_o, .lsu_exc_tval_o
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  task automatic stop_on_failure();
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input string what,
                           input logic [63:0] exp_v, input logic [63:0] act_v);
    assert (act_v === exp_v) else begin
      $display("[ERROR] %s: %s expected %0h actual %0h", name, what, exp_v, act_v);
      stop_on_failure();
    end
  endtask

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // canonical address inside a page, random below the page boundary
  function automatic logic [63:0] addr_in(input logic [26:0] vpn, input logic [1:0] size);
    logic [31:0] r;
    logic [38:0] va;
    r  = rnd();
    va = {vpn, r[11:0]};
    if (size == PAGE_1G) begin
      va[29:12] = r[29:12];
    end else if (size == PAGE_2M) begin
      va[20:12] = r[20:12];
    end
    return {{25{va[38]}}, va};
  endfunction

  // mostly live entries, some addresses with top bit 8 set which never load
  function automatic logic [63:0] pick_addr();
    logic [31:0] r;
    int          idx;
    r   = rnd();
    idx = r[1:0];
    if (m_valid[idx] && (r[4:2] != 3'd0)) begin
      return addr_in(m_vpn[idx], m_size[idx]);
    end
    return addr_in({1'b1, r[31:6]}, PAGE_4K);
  endfunction

  task automatic write_cfg(input logic [3:0] addr, input logic [63:0] data);
    @(posedge clk_i);
    lsu_req_i   <= 1'b0;
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= data;
    @(posedge clk_i);
    cfg_we_i    <= 1'b0;
  endtask

  task automatic set_ctrl(input logic en, input logic [1:0] priv, input logic sum,
                          input logic mxr);
    logic [63:0] val;
    val = {59'd0, mxr, sum, priv, en};
    write_cfg(REG_CTRL, val);
    m_en   = en;
    m_priv = priv;
    m_sum  = sum;
    m_mxr  = mxr;
    @(negedge clk_i);
    check_val("ctrl_readback", "rdata", val, cfg_rdata_o);
  endtask

  task automatic load_entry(input logic [26:0] vpn, input logic [1:0] size,
                            input logic [43:0] ppn, input logic [7:0] flags);
    write_cfg(REG_ENTRY_VPN, {35'd0, size, vpn});
    write_cfg(REG_ENTRY_PTE, {10'd0, ppn, 2'b00, flags});
    model_refill(vpn, size, ppn, flags);
  endtask

  // every entry gets its own top vpn level so no two entries overlap
  task automatic load_random_entry();
    logic [31:0] r;
    logic [31:0] p;
    logic [31:0] f;
    logic [26:0] vpn;
    logic [1:0]  size;
    r        = rnd();
    p        = rnd();
    f        = rnd();
    vpn      = {next_top, r[17:0]};
    size     = (r[31:30] == 2'd3) ? 2'd0 : r[31:30];
    next_top = next_top + 9'd1;
    load_entry(vpn, size, {r[29:18], p}, f[7:0]);
    hist_va.push_back(addr_in(vpn, size));
  endtask

  task automatic issue(input logic [63:0] va, input logic st, input logic mis);
    @(posedge clk_i);
    lsu_req_i        <= 1'b1;
    lsu_vaddr_i      <= va;
    lsu_is_store_i   <= st;
    lsu_misaligned_i <= mis;
    exp_q.push_back(model_expect(va, st, mis, cyc + 1));
    name_q.push_back(test_name);
  endtask

  task automatic idle();
    @(posedge clk_i);
    lsu_req_i <= 1'b0;
  endtask

  // ------------------------------------------------------------------
  // response checking at the falling edge
  // ------------------------------------------------------------------
  task automatic check_response();
    exp_t  e;
    string name;
    // same cycle hit for the request on the inputs now
    if (lsu_req_i) begin
      e = exp_q[$];
      check_val(name_q[$], "dtlb_hit", e.dhit, lsu_dtlb_hit_o);
    end
    if ((exp_q.size() != 0) && (exp_q[0].tag + 1 == cyc)) begin
      e    = exp_q.pop_front();
      name = name_q.pop_front();
      check_val(name, "miss", e.miss, lsu_miss_o);
      check_val(name, "valid", !e.miss, lsu_valid_o);
      check_val(name, "exc_valid", e.exc, lsu_exc_valid_o);
      if (e.exc) begin
        check_val(name, "exc_cause", e.cause, lsu_exc_cause_o);
        check_val(name, "exc_tval", e.tval, lsu_exc_tval_o);
      end else if (!e.miss) begin
        check_val(name, "paddr", e.paddr, lsu_paddr_o);
      end
    end else begin
      assert (!lsu_valid_o && !lsu_miss_o) else begin
        $display("response pulse without a request in the cycle before");
        stop_on_failure();
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_response();
    end
  end

  // ------------------------------------------------------------------
  // test phases
  // ------------------------------------------------------------------
  task automatic run_xlat_off();
    logic [31:0] r;
    logic [63:0] va;
    test_name = "xlat_off";
    repeat (24) begin
      r  = rnd();
      va = {rnd(), rnd()};
      // about half of them canonical
      if (r[0]) begin
        va = {{25{va[38]}}, va[38:0]};
      end
      issue(va, r[1], r[2] & r[3]);
    end
    idle();
  endtask

  task automatic run_refill_hit();
    logic [31:0] r;
    test_name = "refill_hit";
    set_ctrl(1'b1, PRIV_M, 1'b0, 1'b0);
    repeat (4) load_random_entry();
    repeat (32) begin
      r = rnd();
      issue(pick_addr(), r[0], 1'b0);
    end
    idle();
  endtask

  task automatic run_round_robin();
    logic [31:0] r;
    test_name = "round_robin";
    repeat (6) load_random_entry();
    foreach (hist_va[i]) issue(hist_va[i], 1'b0, 1'b0);
    // exact match refill keeps the pointer where it is
    r = rnd();
    load_entry(m_vpn[1], m_size[1], {r[11:0], rnd()}, m_flags[1]);
    load_random_entry();
    foreach (hist_va[i]) issue(hist_va[i], 1'b1, 1'b0);
    idle();
  endtask

  task automatic run_perm_faults();
    logic [31:0] r;
    logic [63:0] va;
    logic [1:0]  priv;
    test_name = "perm_fault";
    repeat (40) begin
      r    = rnd();
      priv = (r[1:0] == 2'd2) ? 2'd3 : r[1:0];
      set_ctrl(1'b1, priv, r[2], r[3]);
      load_random_entry();
      va = hist_va[$];
      if (r[4] && r[5]) begin
        va[50] = !va[50];
      end
      issue(va, r[6], r[7] & r[8]);
      issue(pick_addr(), r[9], 1'b0);
    end
    idle();
  endtask

  task automatic run_flush();
    test_name = "flush";
    set_ctrl(1'b1, PRIV_S, 1'b1, 1'b1);
    for (int i = hist_va.size() - 4; i < hist_va.size(); i++) begin
      issue(hist_va[i], 1'b0, 1'b0);
    end
    write_cfg(REG_FLUSH, 64'd0);
    model_flush();
    for (int i = hist_va.size() - 8; i < hist_va.size(); i++) begin
      issue(hist_va[i], 1'b0, 1'b0);
    end
    idle();
  endtask

  task automatic run_back_to_back();
    logic [31:0] r;
    test_name = "back_to_back";
    set_ctrl(1'b1, PRIV_U, 1'b0, 1'b1);
    repeat (4) load_random_entry();
    repeat (60) begin
      r = rnd();
      issue(pick_addr(), r[0], r[1] & r[2] & r[3]);
    end
    idle();
  endtask

  initial begin
    seed             = 32'h98ebc413;
    next_top         = 9'd0;
    test_name        = "reset";
    rst_ni           <= 1'b0;
    cfg_we_i         <= 1'b0;
    cfg_addr_i       <= '0;
    cfg_wdata_i      <= '0;
    lsu_req_i        <= 1'b0;
    lsu_vaddr_i      <= '0;
    lsu_is_store_i   <= 1'b0;
    lsu_misaligned_i <= 1'b0;
    model_reset();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    run_xlat_off();
    run_refill_hit();
    run_round_robin();
    run_perm_faults();
    run_flush();
    run_back_to_back();

    // let the last results come back
    wait_cnt = 0;
    while ((exp_q.size() != 0) && (wait_cnt < 10)) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout waiting for outstanding translation results");
      stop_on_failure();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// ==== src.f ====
+incdir+verif
src/mmu_pkg.sv
src/mmu_csr_pkg.sv
src/mmu_cfg_regs.sv
src/dtlb.sv
src/pte_perm_check.sv
src/lsu_xlat_stage.sv
src/mmu_top.sv
verif/mmu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the data MMU testbench with Verilator
verilator --binary --assert -Wno-fatal --top-module mmu_tb \
  -f src.f -o mmu_sim \
  && ./obj_dir/mmu_sim \
  || exit 1
